//--- hw/vga_timing_pkg.sv
// VGA timing package
// 640x480 line and frame geometry, image box placement and RGB565 colours

package vga_timing_pkg;

    parameter int h_active = 640;   // pixels
    parameter int h_front  = 16;
    parameter int h_sync   = 96;
    parameter int h_back   = 48;
    parameter int h_total  = 800;

    parameter int v_active = 480;   // lines
    parameter int v_front  = 10;
    parameter int v_sync   = 2;
    parameter int v_back   = 33;
    parameter int v_total  = 525;

    // top-left corner of the 256x256 image box
    parameter int box_x0         = 192;
    parameter int box_y0         = 112;
    parameter int box_scale_log2 = 4;   // 16 screen pixels per image pixel

    parameter logic [15:0] color_fg     = 16'hffff;
    parameter logic [15:0] color_bg     = 16'h0000;
    parameter logic [15:0] color_border = 16'h0010;

    parameter int hcount_w = 10;
    parameter int vcount_w = 10;

endpackage

//--- hw/image_pkg.sv
// image store package
// geometry of the monochrome images and their ROM and row buffer addressing

package image_pkg;

    parameter int img_rows  = 16;   // rows per image
    parameter int img_width = 16;   // pixels per row, one bit each
    parameter int img_count = 16;

    // buffer row address
    parameter int row_addr_w = 4;

    // {image index, row}
    parameter int rom_addr_w = 8;

endpackage

//--- hw/image_rom.sv
// image ROM
// 16 images of 16 rows, each word built from image index and row, one cycle latency

`timescale 1ns/100ps

module image_rom
(
    input  logic                             clk_vga,
    input  logic [image_pkg::rom_addr_w-1:0] addr,
    output logic [image_pkg::img_width-1:0]  data
);

    import image_pkg::*;

    logic [rom_addr_w-row_addr_w-1:0] img_idx;
    logic [row_addr_w-1:0]            row_idx;

    assign img_idx = addr[rom_addr_w-1:row_addr_w];
    assign row_idx = addr[row_addr_w-1:0];

    // contents are {k, r, ~k, ~r}, no init file
    always_ff @(posedge clk_vga)
    begin
        data <= {img_idx, row_idx, ~img_idx, ~row_idx};
    end

endmodule

//--- hw/image_sequencer.sv
// image sequencer
// copies one image from the ROM into the display row buffer, holds it, then moves on

`timescale 1ns/100ps

module image_sequencer
#(
    parameter int unsigned hold_cycles = 6_250_000
)
(
    input  logic                             clk_vga,
    input  logic                             rst_n,
    output logic [image_pkg::rom_addr_w-1:0] rom_addr,
    input  logic [image_pkg::img_width-1:0]  rom_data,
    output logic                             write_en,
    output logic [image_pkg::row_addr_w-1:0] write_addr,
    output logic [image_pkg::img_width-1:0]  write_data
);

    import image_pkg::*;

    localparam int idx_w = rom_addr_w - row_addr_w;
    // hold also covers the cycle of the last write and the index step
    localparam int cnt_w = $clog2(hold_cycles + 2);

    localparam logic st_load = 1'b0;
    localparam logic st_hold = 1'b1;

    logic             state;
    logic [idx_w-1:0] image;        // image being shown
    logic [row_addr_w-1:0] row;     // row being fetched
    logic [cnt_w-1:0] hold_cnt;

    assign rom_addr   = {image, row};
    assign write_data = rom_data;   // ROM word lines up with the registered strobe

    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= st_load;
            image      <= '0;
            row        <= '0;
            hold_cnt   <= '0;
            write_en   <= 1'b0;
            write_addr <= '0;
        end
        else
        begin
            write_en <= 1'b0;
            case (state)
                st_load:
                begin
                    write_en   <= 1'b1;         // word for this row returns next cycle
                    write_addr <= row;
                    row        <= row + 1'b1;   // wraps to 0 for the next image
                    if (row == row_addr_w'(img_rows - 1))
                        state <= st_hold;
                end
                st_hold:
                begin
                    if (hold_cnt == cnt_w'(hold_cycles + 1))
                    begin
                        hold_cnt <= '0;
                        state    <= st_load;
                        if (image == idx_w'(img_count - 1))
                            image <= '0;
                        else
                            image <= image + 1'b1;
                    end
                    else
                    begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: state <= st_load;
            endcase
        end
    end

    // only the last row's write may overlap the hold state
    assert property (@(posedge clk_vga) disable iff (!rst_n)
        (state == st_hold && write_en) |-> $past(state == st_load));

    assert property (@(posedge clk_vga) disable iff (!rst_n)
        image < img_count);

endmodule

//--- hw/sync_gen.sv
// VGA sync generator
// pixel and line counters with decoded sync pulses and active-area flag

`timescale 1ns/100ps

module sync_gen
(
    input  logic                               clk_vga,
    input  logic                               rst_n,
    output logic [vga_timing_pkg::hcount_w-1:0] hcount,
    output logic [vga_timing_pkg::vcount_w-1:0] vcount,
    output logic                               hsync,
    output logic                               vsync,
    output logic                               active
);

    import vga_timing_pkg::*;

    localparam int hs_start = h_active + h_front;   // 656
    localparam int hs_end   = hs_start + h_sync;    // first pixel after the pulse
    localparam int vs_start = v_active + v_front;   // 490
    localparam int vs_end   = vs_start + v_sync;

    logic h_last;
    logic v_last;

    assign h_last = (hcount == hcount_w'(h_total - 1));
    assign v_last = (vcount == vcount_w'(v_total - 1));

    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hcount <= '0;
            vcount <= '0;
        end
        else
        begin
            if (h_last)
            begin
                hcount <= '0;
                vcount <= v_last ? '0 : vcount + 1'b1;   // one line per h wrap
            end
            else
            begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // both pulses active low
    assign hsync  = !((hcount >= hs_start) && (hcount < hs_end));
    assign vsync  = !((vcount >= vs_start) && (vcount < vs_end));
    assign active = (hcount < h_active) && (vcount < v_active);

    assert property (@(posedge clk_vga) disable iff (!rst_n)
        (hcount < h_total) && (vcount < v_total));

endmodule

//--- hw/vga_interface.sv
// VGA display interface
// row buffer of the current image, scaled pixel lookup and two-stage colour pipeline

`timescale 1ns/100ps

module vga_interface
(
    input  logic                             clk_vga,
    input  logic                             rst_n,
    input  logic                             write_en,
    input  logic [image_pkg::row_addr_w-1:0] write_addr,
    input  logic [image_pkg::img_width-1:0]  write_data,
    output logic                             hsync,
    output logic                             vsync,
    output logic [4:0]                       red,
    output logic [5:0]                       green,
    output logic [4:0]                       blue
);

    import vga_timing_pkg::*;
    import image_pkg::*;

    localparam int box_w = img_width << box_scale_log2;   // 256
    localparam int box_h = img_rows << box_scale_log2;
    localparam int col_w = $clog2(img_width);

    logic [hcount_w-1:0]  hcount;
    logic [vcount_w-1:0]  vcount;
    logic                 hsync_raw;
    logic                 vsync_raw;
    logic                 active_raw;
    logic [img_width-1:0] row_buf [img_rows];
    logic [hcount_w-1:0]  hrel;
    logic [vcount_w-1:0]  vrel;
    logic [hcount_w-1:0]  col;
    logic [vcount_w-1:0]  vrow;
    logic [col_w-1:0]     bit_sel;
    logic                 in_box;
    logic                 pix_q;
    logic                 in_box_q;
    logic                 active_q;
    logic                 hsync_q;
    logic                 vsync_q;
    logic [15:0]          color;

    sync_gen u_sync_gen
    (
        .clk_vga (clk_vga),
        .rst_n   (rst_n),
        .hcount  (hcount),
        .vcount  (vcount),
        .hsync   (hsync_raw),
        .vsync   (vsync_raw),
        .active  (active_raw)
    );

    // screen starts on a blank image
    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < img_rows; i++)
                row_buf[i] <= '0;
        end
        else if (write_en)
        begin
            row_buf[write_addr] <= write_data;
        end
    end

    assign hrel    = hcount - hcount_w'(box_x0);
    assign vrel    = vcount - vcount_w'(box_y0);
    assign col     = hrel >> box_scale_log2;
    assign vrow    = vrel >> box_scale_log2;
    assign bit_sel = col_w'(img_width - 1) - col[col_w-1:0];   // msb on the left
    assign in_box  = (hcount >= box_x0) && (hcount < box_x0 + box_w) &&
                     (vcount >= box_y0) && (vcount < box_y0 + box_h);

    always_ff @(posedge clk_vga)
    begin
        pix_q <= row_buf[vrow[row_addr_w-1:0]][bit_sel];
    end

    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_box_q <= 1'b0;
            active_q <= 1'b0;
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
        end
        else
        begin
            in_box_q <= in_box;
            active_q <= active_raw;
            hsync_q  <= hsync_raw;
            vsync_q  <= vsync_raw;
        end
    end

    always_comb
    begin
        if (!active_q)
            color = '0;             // blanking
        else if (!in_box_q)
            color = color_border;
        else
            color = pix_q ? color_fg : color_bg;
    end

    // second stage keeps syncs aligned with colour
    always_ff @(posedge clk_vga or negedge rst_n)
    begin
        if (!rst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else
        begin
            red   <= color[15:11];
            green <= color[10:5];
            blue  <= color[4:0];
            hsync <= hsync_q;
            vsync <= vsync_q;
        end
    end

    assert property (@(posedge clk_vga) disable iff (!rst_n)
        write_en |-> !$isunknown(write_addr));

endmodule

//--- hw/vga_slideshow_top.sv
// VGA slideshow top level
// image ROM, sequencer and display interface in the clk_vga domain

`timescale 1ns/100ps

module vga_slideshow_top
#(
    parameter int unsigned hold_cycles = 6_250_000   // 250 ms at 25 MHz
)
(
    input  logic       clk_vga,
    input  logic       rst_n,
    output logic       hsync,
    output logic       vsync,
    output logic [4:0] red,
    output logic [5:0] green,
    output logic [4:0] blue
);

    import image_pkg::*;

    logic [rom_addr_w-1:0] rom_addr;
    logic [img_width-1:0]  rom_data;
    logic                  write_en;
    logic [row_addr_w-1:0] write_addr;
    logic [img_width-1:0]  write_data;

    image_rom u_image_rom
    (
        .clk_vga (clk_vga),
        .addr    (rom_addr),
        .data    (rom_data)
    );

    image_sequencer #(.hold_cycles(hold_cycles)) u_image_sequencer
    (
        .clk_vga    (clk_vga),
        .rst_n      (rst_n),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data)
    );

    vga_interface u_vga_interface
    (
        .clk_vga    (clk_vga),
        .rst_n      (rst_n),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .hsync      (hsync),
        .vsync      (vsync),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

//--- tb/tb_vga_slideshow.sv
// testbench for the VGA slideshow
// cycle model of sequencer, row buffer and timing, with random colour samples per line

`timescale 1ns/100ps

module tb_vga_slideshow;

    import vga_timing_pkg::*;
    import image_pkg::*;

    localparam int hold         = 3000;
    localparam int load_period  = hold + 18;   // one load start to the next
    localparam int run_cycles   = 3 * h_total * v_total;
    localparam int reset_cycles = 10;
    localparam int clk_period   = 40;
    localparam int box_size     = img_width << box_scale_log2;
    localparam longint watchdog_ns =
        (longint'(run_cycles) * 11 / 10 + reset_cycles) * clk_period;

    logic               clk_vga;
    logic               rst_n;
    logic               hsync;
    logic               vsync;
    logic [4:0]         red;
    logic [5:0]         green;
    logic [4:0]         blue;
    logic [15:0]        model_buf [img_rows];
    logic [h_total-1:0] sample_flag;   // hcount positions checked on this line
    int                 seed;
    int                 loads;         // load periods seen through box samples
    int                 last_load;
    int                 sync_checks;
    int                 color_checks;
    int                 box_checks;
    int                 sync_errors;
    int                 color_errors;
    int                 other_errors;

    vga_slideshow_top #(.hold_cycles(hold)) UUT
    (
        .clk_vga (clk_vga),
        .rst_n   (rst_n),
        .hsync   (hsync),
        .vsync   (vsync),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    function automatic logic [15:0] img_word(int k, int r);
        logic [3:0] k4;
        logic [3:0] r4;
        k4 = 4'(k);
        r4 = 4'(r);
        return {k4, r4, ~k4, ~r4};
    endfunction

    // buffer write landing on rising edge w
    task automatic apply_write(int w);
        int p;
        p = w % load_period;
        if (p >= 1 && p <= img_rows)
            model_buf[p-1] = img_word((w / load_period) % img_count, p - 1);
    endtask

    function automatic logic [15:0] expected_color(int t);
        int h;
        int v;
        int col;
        h = t % h_total;
        v = (t / h_total) % v_total;
        if (t < 0 || h >= h_active || v >= v_active)
            return 16'h0000;
        if (h < box_x0 || h >= box_x0 + box_size || v < box_y0 || v >= box_y0 + box_size)
            return color_border;
        col = (h - box_x0) >> box_scale_log2;   // msb is the leftmost pixel
        return model_buf[(v - box_y0) >> box_scale_log2][img_width-1-col] ? color_fg : color_bg;
    endfunction

    task automatic pick_samples();
        sample_flag = '0;
        repeat (32)
            sample_flag[$unsigned($random(seed)) % h_total] = 1'b1;
    endtask

    task automatic check_buffer_clear();
        for (int i = 0; i < img_rows; i++)
        begin
            assert (UUT.u_vga_interface.row_buf[i] === 16'h0000)
            else
            begin
                other_errors++;
                $display("[FAIL] %0t row_buf[%0d] expected 0000 got %h",
                         $time, i, UUT.u_vga_interface.row_buf[i]);
            end
        end
    endtask

    initial
    begin
        clk_vga = 1'b0;
        forever #(clk_period/2) clk_vga = ~clk_vga;
    end

    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired before all cycles were checked");
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int          t;
        int          h;
        int          v;
        logic        exp_hs;
        logic        exp_vs;
        logic [15:0] exp_rgb;
        seed = 32'hb624;
        loads = 0;
        last_load = -1;
        sync_checks = 0;
        color_checks = 0;
        box_checks = 0;
        sync_errors = 0;
        color_errors = 0;
        other_errors = 0;
        sample_flag = '0;
        for (int i = 0; i < img_rows; i++)
            model_buf[i] = '0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_vga);
        @(negedge clk_vga);
        rst_n = 1'b1;
        // outputs after rising edge e show counter value e-1
        for (int e = 0; e < run_cycles; e++)
        begin
            @(negedge clk_vga);
            t = e - 1;
            h = (t < 0) ? -1 : t % h_total;
            v = (t < 0) ? -1 : (t / h_total) % v_total;
            if (e == 0)
                check_buffer_clear();   // no write has landed yet
            exp_hs = !(h >= h_active + h_front && h < h_active + h_front + h_sync);
            exp_vs = !(v >= v_active + v_front && v < v_active + v_front + v_sync);
            sync_checks++;
            assert (hsync === exp_hs)
            else
            begin
                sync_errors++;
                $display("[FAIL] %0t hsync expected %b got %b", $time, exp_hs, hsync);
            end
            assert (vsync === exp_vs)
            else
            begin
                sync_errors++;
                $display("[FAIL] %0t vsync expected %b got %b", $time, exp_vs, vsync);
            end
            if (h == 0)
                pick_samples();
            if (t < 0 || sample_flag[h])
            begin
                exp_rgb = expected_color(t);
                color_checks++;
                if (h >= box_x0 && h < box_x0 + box_size && v >= box_y0 && v < box_y0 + box_size)
                begin
                    box_checks++;
                    if ((t - 1) / load_period != last_load)
                    begin
                        loads++;   // first box sample of this load period
                        last_load = (t - 1) / load_period;
                    end
                end
                assert ({red, green, blue} === exp_rgb)
                else
                begin
                    color_errors++;
                    $display("[FAIL] %0t {red,green,blue} expected %h got %h",
                             $time, exp_rgb, {red, green, blue});
                end
            end
            apply_write(e - 1);
        end
        if (loads < img_count + 5)
        begin
            other_errors++;
            $display("box samples cover fewer than 21 images, so the wrap is not shown");
        end
        if (box_checks == 0)
        begin
            other_errors++;
            $display("no pixel inside the image box was sampled");
        end
        $display("checks sync %0d colour %0d box %0d, errors sync %0d colour %0d other %0d",
                 sync_checks, color_checks, box_checks, sync_errors, color_errors,
                 other_errors);
        if (sync_errors + color_errors + other_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- vga_slideshow.f
hw/vga_timing_pkg.sv
hw/image_pkg.sv
hw/image_rom.sv
hw/image_sequencer.sv
hw/sync_gen.sv
hw/vga_interface.sv
hw/vga_slideshow_top.sv
tb/tb_vga_slideshow.sv
